//--- Makefile
VERILATOR  := verilator
TOP        := tb_cpu
FILELIST   := sources.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
PASS_MSG   := Verification passed
FAIL_MSG   := Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- alu.sv
`timescale 1ns/10ps

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = word_t'(lt);
      default: result = '0;
    endcase
  end

endmodule

//--- clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- cpu_assert.sv
`timescale 1ns/10ps

module cpu_assert (
  input logic         clk,
  input logic         arst_n,
  input logic         instr_valid,
  input logic         queue_full,
  input logic         wb_valid,
  input cpu_pkg::wb_t wb
);

  a_wb_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_valid)
    else $error("wb_valid high while reset is asserted");

  a_wb_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> (wb.dest != '0))
    else $error("writeback targets register 0");

  // full only follows a push on the edge before
  a_full_after_push: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(queue_full) |-> $past(instr_valid))
    else $error("queue_full rose without a push");

  a_wb_known: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> !$isunknown(wb))
    else $error("wb holds unknown bits while wb_valid is high");

endmodule

//--- cpu_core.sv
`timescale 1ns/10ps

module cpu_core #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_valid,
  input  cpu_pkg::instr_t instr,
  input  logic            hold,
  output logic            queue_full,
  output logic            wb_valid,
  output cpu_pkg::wb_t    wb
);
  import cpu_pkg::*;

  uop_t dec_uop;
  logic dec_valid;
  uop_t head;
  logic empty;
  logic pop;

  instr_decoder u_decoder (
    .instr       (instr),
    .instr_valid (instr_valid),
    .uop         (dec_uop),
    .uop_valid   (dec_valid)
  );

  op_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (dec_valid),
    .push_uop   (dec_uop),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .queue_full (queue_full)
  );

  exec_pipe u_exec (
    .clk      (clk),
    .arst_n   (arst_n),
    .head     (head),
    .empty    (empty),
    .hold     (hold),
    .pop      (pop),
    .wb_valid (wb_valid),
    .wb       (wb)
  );

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm_t;

  localparam int NUM_REGS = 32;

  // instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  // r-type
  localparam opcode_t OP_ADD  = 6'h00;
  localparam opcode_t OP_SUB  = 6'h01;
  localparam opcode_t OP_AND  = 6'h02;
  localparam opcode_t OP_OR   = 6'h03;
  localparam opcode_t OP_SLT  = 6'h04;
  // i-type, immediate zero-extended
  localparam opcode_t OP_ADDI = 6'h08;
  localparam opcode_t OP_ORI  = 6'h0D;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    imm_t     imm;
    logic     use_imm;
    logic     reg_write;
  } uop_t;

  typedef struct packed {
    reg_idx_t dest;
    word_t    data;
  } wb_t;

endpackage

//--- exec_pipe.sv
`timescale 1ns/10ps

module exec_pipe (
  input  logic          clk,
  input  logic          arst_n,
  input  cpu_pkg::uop_t head,
  input  logic          empty,
  input  logic          hold,
  output logic          pop,
  output logic          wb_valid,
  output cpu_pkg::wb_t  wb
);
  import cpu_pkg::*;

  word_t rd_data_a;
  word_t rd_data_b;
  logic  iss_write;
  uop_t  iss_uop;
  word_t iss_a;
  word_t iss_b;
  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_result;

  // bypass from the writeback register, never for r0
  function automatic word_t fwd(input reg_idx_t idx, input word_t data);
    word_t sel;
    if (wb_valid && (idx != '0) && (wb.dest == idx)) begin
      sel = wb.data;
    end else begin
      sel = data;
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////
  // issue / register read
  //////////////////////////////////////////////////

  assign pop = !hold && !empty;

  reg_file u_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (head.rs),
    .rd_addr_b (head.rt),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_valid),
    .wr        (wb)
  );

  // bubble when nothing is popped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      iss_write <= 1'b0;
    end else begin
      iss_write <= pop && head.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    iss_uop <= head;
    iss_a   <= rd_data_a;
    iss_b   <= rd_data_b;
  end

  //////////////////////////////////////////////////
  // execute
  //////////////////////////////////////////////////

  always_comb begin
    op_a = fwd(iss_uop.rs, iss_a);
    op_b = fwd(iss_uop.rt, iss_b);
  end

  assign alu_b = iss_uop.use_imm ? {16'h0000, iss_uop.imm} : op_b;

  alu u_alu (
    .op     (iss_uop.alu_op),
    .a      (op_a),
    .b      (alu_b),
    .result (alu_result)
  );

  //////////////////////////////////////////////////
  // writeback
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= iss_write;
    end
  end

  always_ff @(posedge clk) begin
    wb.dest <= iss_uop.dest;
    wb.data <= alu_result;
  end

endmodule

//--- instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  cpu_pkg::instr_t instr,
  input  logic            instr_valid,
  output cpu_pkg::uop_t   uop,
  output logic            uop_valid
);
  import cpu_pkg::*;

  opcode_t  opcode;
  reg_idx_t rt;
  reg_idx_t rd;
  logic     known;
  logic     use_rd;
  logic     use_imm;
  alu_op_e  alu_op;

  assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
  assign rt     = instr[RT_MSB:RT_LSB];
  assign rd     = instr[RD_MSB:RD_LSB];

  // control decode
  always_comb begin
    known   = 1'b1;
    use_rd  = 1'b1;
    use_imm = 1'b0;
    alu_op  = ALU_ADD;
    case (opcode)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_SLT:  alu_op = ALU_SLT;
      OP_ADDI: begin
        alu_op  = ALU_ADD;
        use_rd  = 1'b0;
        use_imm = 1'b1;
      end
      OP_ORI: begin
        alu_op  = ALU_OR;
        use_rd  = 1'b0;
        use_imm = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  always_comb begin
    uop.alu_op    = alu_op;
    uop.rs        = instr[RS_MSB:RS_LSB];
    uop.rt        = rt;
    uop.dest      = use_rd ? rd : rt;
    uop.imm       = instr[IMM_MSB:IMM_LSB];
    uop.use_imm   = use_imm;
    // unknown opcodes and r0 targets retire silently
    uop.reg_write = known && (uop.dest != '0);
  end

  assign uop_valid = instr_valid;

endmodule

//--- op_queue.sv
`timescale 1ns/10ps

module op_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          push,
  input  cpu_pkg::uop_t push_uop,
  input  logic          pop,
  output cpu_pkg::uop_t head,
  output logic          empty,
  output logic          queue_full
);
  import cpu_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  uop_t             mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign queue_full = (count == CNT_W'(QUEUE_DEPTH));
  assign empty      = (count == '0);
  assign do_push    = push && !queue_full;
  assign do_pop     = pop && !empty;
  assign head       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic             clk,
  input  logic             arst_n,
  input  cpu_pkg::reg_idx_t rd_addr_a,
  input  cpu_pkg::reg_idx_t rd_addr_b,
  output cpu_pkg::word_t   rd_data_a,
  output cpu_pkg::word_t   rd_data_b,
  input  logic             wr_en,
  input  cpu_pkg::wb_t     wr
);
  import cpu_pkg::*;

  word_t regs [NUM_REGS];

  // r0 reads zero, same-cycle write passes through
  function automatic word_t read_port(input reg_idx_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en && (wr.dest == addr)) begin
      data = wr.data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr.dest != '0)) begin
      regs[wr.dest] <= wr.data;
    end
  end

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

endmodule

//--- sources.f
cpu_pkg.sv
alu.sv
reg_file.sv
instr_decoder.sv
op_queue.sv
exec_pipe.sv
cpu_core.sv
clk_gen.sv
cpu_assert.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int WAIT_LIMIT  = 200;

  logic   clk;
  logic   arst_n;
  logic   instr_valid;
  instr_t instr;
  logic   hold;
  logic   queue_full;
  logic   wb_valid;
  wb_t    wb;

  word_t model_regs [NUM_REGS];
  wb_t   exp_q [$];
  int    mismatches  = 0;
  int    timeouts    = 0;
  int    other_errs  = 0;
  int    wb_seen     = 0;
  int    wb_expected = 0;
  logic  saw_full;

  clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  cpu_core #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .hold        (hold),
    .queue_full  (queue_full),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  bind cpu_core cpu_assert u_cpu_assert (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .queue_full  (queue_full),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  //////////////////////////////////////////////////
  // encoding and reference model
  //////////////////////////////////////////////////

  function automatic instr_t enc_r(input opcode_t op, input reg_idx_t rs,
                                   input reg_idx_t rt, input reg_idx_t rd);
    instr_t w;
    w = '0;
    w[OPCODE_MSB:OPCODE_LSB] = op;
    w[RS_MSB:RS_LSB] = rs;
    w[RT_MSB:RT_LSB] = rt;
    w[RD_MSB:RD_LSB] = rd;
    return w;
  endfunction

  function automatic instr_t enc_i(input opcode_t op, input reg_idx_t rs,
                                   input reg_idx_t rt, input imm_t imm);
    instr_t w;
    w = '0;
    w[OPCODE_MSB:OPCODE_LSB] = op;
    w[RS_MSB:RS_LSB] = rs;
    w[RT_MSB:RT_LSB] = rt;
    w[IMM_MSB:IMM_LSB] = imm;
    return w;
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'($urandom_range(31, 1));
  endfunction

  function automatic instr_t rand_alu(input reg_idx_t rs, input reg_idx_t rt,
                                      input reg_idx_t rd);
    instr_t w;
    case ($urandom_range(5, 0))
      0: w = enc_r(OP_ADD, rs, rt, rd);
      1: w = enc_r(OP_SUB, rs, rt, rd);
      2: w = enc_r(OP_AND, rs, rt, rd);
      3: w = enc_r(OP_OR, rs, rt, rd);
      4: w = enc_r(OP_SLT, rs, rt, rd);
      default: w = enc_i(OP_ADDI, rs, rd, imm_t'($urandom));
    endcase
    return w;
  endfunction

  // applies one instruction to the model, returns 1 when a writeback is due
  function automatic bit model_step(input instr_t ins, output wb_t exp_wb);
    opcode_t  op;
    reg_idx_t dest;
    word_t    a;
    word_t    b;
    word_t    imm_z;
    word_t    res;
    bit       known;
    bit       wr;
    op    = ins[OPCODE_MSB:OPCODE_LSB];
    a     = model_regs[ins[RS_MSB:RS_LSB]];
    b     = model_regs[ins[RT_MSB:RT_LSB]];
    imm_z = {16'h0000, ins[IMM_MSB:IMM_LSB]};
    dest  = ins[RD_MSB:RD_LSB];
    known = 1'b1;
    res   = '0;
    case (op)
      OP_ADD: res = a + b;
      OP_SUB: res = a - b;
      OP_AND: res = a & b;
      OP_OR:  res = a | b;
      OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_ADDI: begin
        res  = a + imm_z;
        dest = ins[RT_MSB:RT_LSB];
      end
      OP_ORI: begin
        res  = a | imm_z;
        dest = ins[RT_MSB:RT_LSB];
      end
      default: known = 1'b0;
    endcase
    wr = known && (dest != '0);
    if (wr) begin
      model_regs[dest] = res;
    end
    exp_wb.dest = dest;
    exp_wb.data = res;
    return wr;
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (arst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("timeout: reset never released");
      timeouts++;
    end
    @(negedge clk);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input instr_t ins);
    wb_t exp_wb;
    int  waited;
    if (model_step(ins, exp_wb)) begin
      exp_q.push_back(exp_wb);
      wb_expected++;
    end
    instr       = ins;
    instr_valid = 1'b1;
    waited      = 0;
    while (queue_full && waited < WAIT_LIMIT) begin
      saw_full = 1'b1;
      @(negedge clk);
      waited++;
    end
    if (queue_full) begin
      $display("timeout: queue stayed full at %0t", $time);
      timeouts++;
    end
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d writebacks never arrived", exp_q.size());
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////

  always @(posedge clk) begin : compare
    wb_t exp_wb;
    if (arst_n && wb_valid) begin
      wb_seen++;
      if (exp_q.size() == 0) begin
        $display("unexpected writeback to r%0d at %0t", wb.dest, $time);
        other_errs++;
      end else begin
        exp_wb = exp_q.pop_front();
        if (wb.dest !== exp_wb.dest) begin
          $display("ERR %0t wb.dest got %0d expected %0d", $time, wb.dest, exp_wb.dest);
          mismatches++;
        end
        if (wb.data !== exp_wb.data) begin
          $display("ERR %0t wb.data got %h expected %h", $time, wb.data, exp_wb.data);
          mismatches++;
        end
      end
    end
  end

  initial begin : stimulus
    int       hold_cycles;
    reg_idx_t prev;
    reg_idx_t older;
    reg_idx_t rd;
    void'($urandom(61));
    instr       = '0;
    instr_valid = 1'b0;
    hold        = 1'b0;
    saw_full    = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    wait_reset();

    // quiet after reset
    repeat (5) begin
      @(negedge clk);
      if (wb_valid !== 1'b0) begin
        $display("ERR %0t wb_valid got %b expected 0", $time, wb_valid);
        mismatches++;
      end
      if (queue_full !== 1'b0) begin
        $display("ERR %0t queue_full got %b expected 0", $time, queue_full);
        mismatches++;
      end
    end
    for (int r = 1; r < NUM_REGS; r++) begin
      send(enc_i(OP_ORI, 5'd0, reg_idx_t'(r), imm_t'($urandom)));
    end
    // negative values for slt
    repeat (8) send(enc_r(OP_SUB, 5'd0, rand_reg(), rand_reg()));
    drain();

    repeat (60) send(rand_alu(rand_reg(), rand_reg(), rand_reg()));
    drain();

    // back to back, forwarded from writeback
    prev = rand_reg();
    repeat (40) begin
      rd = rand_reg();
      send(rand_alu(prev, ($urandom_range(1, 0) != 0) ? prev : rand_reg(), rd));
      prev = rd;
    end
    drain();

    // two apart, through the register file
    older = rand_reg();
    prev  = rand_reg();
    repeat (40) begin
      rd = rand_reg();
      send(rand_alu(older, rand_reg(), rd));
      older = prev;
      prev  = rd;
    end
    drain();

    hold        = 1'b1;
    saw_full    = 1'b0;
    hold_cycles = QUEUE_DEPTH + 4 + int'($urandom_range(8, 0));
    fork
      begin
        repeat (hold_cycles) @(negedge clk);
        hold = 1'b0;
      end
      repeat (3 * QUEUE_DEPTH) send(rand_alu(rand_reg(), rand_reg(), rand_reg()));
    join
    if (!saw_full) begin
      $display("queue_full never rose while hold was high");
      other_errs++;
    end
    drain();

    // r0 targets and unknown opcodes retire silently
    send(enc_r(OP_ADD, rand_reg(), rand_reg(), 5'd0));
    send(enc_i(OP_ORI, rand_reg(), 5'd0, imm_t'($urandom)));
    send(enc_i(OP_ADDI, 5'd0, 5'd0, 16'hFFFF));
    send(enc_r(6'h05, rand_reg(), rand_reg(), rand_reg()));
    repeat (4) send(enc_r(opcode_t'($urandom_range(63, 16)), rand_reg(), rand_reg(), rand_reg()));
    send(enc_r(OP_ADD, 5'd0, rand_reg(), rand_reg()));
    send(enc_r(OP_OR, 5'd0, 5'd0, rand_reg()));
    send(enc_r(OP_SLT, rand_reg(), 5'd0, rand_reg()));
    send(enc_i(OP_ADDI, 5'd0, rand_reg(), imm_t'($urandom)));
    drain();

    repeat (4) @(negedge clk);
    if (wb_seen != wb_expected) begin
      $display("%0d writebacks seen but %0d expected", wb_seen, wb_expected);
      other_errs++;
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, other_errs);
    if (mismatches == 0 && timeouts == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
